//--- source/soc_pkg.sv
// Bus request and response structs, address map, UART constants
// and the region type of the fabric decoder
package soc_pkg;

  localparam int ADDR_W = 16;  // Byte address
  localparam int DATA_W = 32;
  localparam int SEL_W  = DATA_W / 8;

  // Address map
  localparam int DECODE_W     = 4;  // Top address bits used for the region decode
  localparam int LMEM_WORDS   = 256;
  localparam int LMEM_IDX_W   = $clog2(LMEM_WORDS);
  localparam int LMEM_BYTE_AW = LMEM_IDX_W + $clog2(SEL_W);

  localparam logic [ADDR_W-1:0] UART_BASE       = 16'h8000;
  localparam logic [ADDR_W-1:0] UART_TXDATA_OFS = 16'h0000;
  localparam logic [ADDR_W-1:0] UART_STATUS_OFS = 16'h0004;  // Bit 0 is busy

  // 8N1 serial frame
  localparam int UART_CLKS_PER_BIT = 8;
  localparam int UART_FRAME_BITS   = 10;
  localparam int UART_CNT_W        = $clog2(UART_CLKS_PER_BIT);
  localparam int UART_BIT_CNT_W    = $clog2(UART_FRAME_BITS);

  typedef struct packed {
    logic              cyc;
    logic              stb;
    logic              we;
    logic [ADDR_W-1:0] adr;
    logic [DATA_W-1:0] dat;
    logic [SEL_W-1:0]  sel;
  } wb_req_t;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [DATA_W-1:0] dat;
  } wb_rsp_t;

  typedef enum logic [1:0] {
    REGION_LMEM,
    REGION_UART,
    REGION_NONE
  } region_e;

endpackage

//--- source/soc_fabric.sv
// Wishbone address decoder, request router and response combiner
module soc_fabric (
  input  logic             clk_i,
  input  logic             i_rst_n,
  input  soc_pkg::wb_req_t i_wb,
  output soc_pkg::wb_rsp_t o_wb,
  output soc_pkg::wb_req_t o_lmem_req,
  input  soc_pkg::wb_rsp_t i_lmem_rsp,
  output soc_pkg::wb_req_t o_uart_req,
  input  soc_pkg::wb_rsp_t i_uart_rsp
);

  soc_pkg::region_e region;
  logic             none_err;  // Error reply for unmapped addresses

  always_comb begin
    if (i_wb.adr[soc_pkg::ADDR_W-1 -: soc_pkg::DECODE_W] ==
        soc_pkg::UART_BASE[soc_pkg::ADDR_W-1 -: soc_pkg::DECODE_W]) begin
      region = soc_pkg::REGION_UART;
    end else if (i_wb.adr[soc_pkg::ADDR_W-1:soc_pkg::LMEM_BYTE_AW] == '0) begin
      region = soc_pkg::REGION_LMEM;
    end else begin
      region = soc_pkg::REGION_NONE;
    end
  end

  // Only the selected subordinate sees the strobe
  always_comb begin
    o_lmem_req     = i_wb;
    o_uart_req     = i_wb;
    o_lmem_req.cyc = i_wb.cyc && (region == soc_pkg::REGION_LMEM);
    o_lmem_req.stb = i_wb.stb && (region == soc_pkg::REGION_LMEM);
    o_uart_req.cyc = i_wb.cyc && (region == soc_pkg::REGION_UART);
    o_uart_req.stb = i_wb.stb && (region == soc_pkg::REGION_UART);
  end

  always_ff @(posedge clk_i) begin
    if (!i_rst_n) begin
      none_err <= 1'b0;
    end else begin
      none_err <= i_wb.cyc && i_wb.stb && (region == soc_pkg::REGION_NONE) && !none_err;
    end
  end

  always_comb begin
    o_wb.ack = i_lmem_rsp.ack | i_uart_rsp.ack;
    o_wb.err = i_lmem_rsp.err | i_uart_rsp.err | none_err;
    case (region)
      soc_pkg::REGION_LMEM: o_wb.dat = i_lmem_rsp.dat;
      soc_pkg::REGION_UART: o_wb.dat = i_uart_rsp.dat;
      default:              o_wb.dat = '0;
    endcase
  end

endmodule

//--- source/soc_lmem.sv
// Local word memory with byte selects on a Wishbone subordinate port
module soc_lmem (
  input  logic             clk_i,
  input  logic             i_rst_n,
  input  soc_pkg::wb_req_t i_req,
  output soc_pkg::wb_rsp_t o_rsp
);

  logic [soc_pkg::DATA_W-1:0]     mem [soc_pkg::LMEM_WORDS];
  logic [soc_pkg::LMEM_IDX_W-1:0] idx;
  logic [soc_pkg::DATA_W-1:0]     rdata_q;
  logic                           ack_q;
  logic                           req_new;

  assign idx     = i_req.adr[soc_pkg::LMEM_BYTE_AW-1:soc_pkg::LMEM_BYTE_AW-soc_pkg::LMEM_IDX_W];
  assign req_new = i_req.cyc && i_req.stb && !ack_q;  // A held strobe is answered once

  always_ff @(posedge clk_i) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= req_new;
    end
  end

  always_ff @(posedge clk_i) begin
    if (req_new) begin
      if (i_req.we) begin
        for (int b = 0; b < soc_pkg::SEL_W; b++) begin
          if (i_req.sel[b]) mem[idx][b*8 +: 8] <= i_req.dat[b*8 +: 8];
        end
      end
      rdata_q <= mem[idx];  // Whole word, sel ignored on reads
    end
  end

  always_comb begin
    o_rsp.ack = ack_q;
    o_rsp.err = 1'b0;
    o_rsp.dat = rdata_q;
  end

endmodule

//--- source/soc_uart.sv
// Transmit-only 8N1 UART with data and status registers
// on a Wishbone subordinate port
module soc_uart (
  input  logic             clk_i,
  input  logic             i_rst_n,
  input  soc_pkg::wb_req_t i_req,
  output soc_pkg::wb_rsp_t o_rsp,
  output logic             o_uart_tx
);

  logic [soc_pkg::ADDR_W-1:0]          ofs;
  logic                                is_tx;
  logic                                is_stat;
  logic                                req;
  logic                                accept_tx;
  logic                                read_ok;
  logic                                bad_req;
  logic                                ack_q;
  logic                                err_q;
  logic [soc_pkg::DATA_W-1:0]          rdata_q;
  logic                                start_q;
  logic                                busy;
  logic [soc_pkg::UART_FRAME_BITS-1:0] frame;
  logic [soc_pkg::UART_CNT_W-1:0]      clk_cnt;
  logic [soc_pkg::UART_BIT_CNT_W-1:0]  bit_cnt;
  logic                                bit_end;

  assign ofs     = {{soc_pkg::DECODE_W{1'b0}},
                    i_req.adr[soc_pkg::ADDR_W-soc_pkg::DECODE_W-1:0]};
  assign is_tx   = (ofs == soc_pkg::UART_TXDATA_OFS);
  assign is_stat = (ofs == soc_pkg::UART_STATUS_OFS);
  assign req     = i_req.cyc && i_req.stb && !ack_q && !err_q;

  // A data write waits here while a frame is on the line
  assign accept_tx = req && i_req.we && is_tx && !busy && !start_q;
  assign read_ok   = req && !i_req.we && (is_tx || is_stat);
  assign bad_req   = req && ((i_req.we && is_stat) || !(is_tx || is_stat));
  assign bit_end   = (clk_cnt == soc_pkg::UART_CNT_W'(soc_pkg::UART_CLKS_PER_BIT - 1));

  always_ff @(posedge clk_i) begin
    if (!i_rst_n) begin
      ack_q <= 1'b0;
      err_q <= 1'b0;
    end else begin
      ack_q <= accept_tx || read_ok;
      err_q <= bad_req;
    end
  end

  always_ff @(posedge clk_i) begin
    if (read_ok) begin
      rdata_q <= is_stat ? {{(soc_pkg::DATA_W-1){1'b0}}, busy} : '0;
    end
  end

  // Bit timing, the start bit goes out the cycle after the ack
  always_ff @(posedge clk_i) begin
    if (!i_rst_n) begin
      start_q <= 1'b0;
      busy    <= 1'b0;
      clk_cnt <= '0;
      bit_cnt <= '0;
    end else begin
      start_q <= accept_tx;
      if (start_q) begin
        busy    <= 1'b1;
        clk_cnt <= '0;
        bit_cnt <= '0;
      end else if (busy) begin
        if (bit_end) begin
          clk_cnt <= '0;
          if (bit_cnt == soc_pkg::UART_BIT_CNT_W'(soc_pkg::UART_FRAME_BITS - 1)) begin
            busy <= 1'b0;  // Stop bit done
          end else begin
            bit_cnt <= bit_cnt + 1'b1;
          end
        end else begin
          clk_cnt <= clk_cnt + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept_tx) begin
      frame <= {1'b1, i_req.dat[7:0], 1'b0};  // Stop, data LSB first, start
    end else if (busy && bit_end) begin
      frame <= {1'b1, frame[soc_pkg::UART_FRAME_BITS-1:1]};
    end
  end

  assign o_uart_tx = busy ? frame[0] : 1'b1;

  always_comb begin
    o_rsp.ack = ack_q;
    o_rsp.err = err_q;
    o_rsp.dat = rdata_q;
  end

endmodule

//--- source/soc_top.sv
// Top level with the bus fabric, local memory and UART
module soc_top (
  input  logic             clk_i,
  input  logic             i_rst_n,
  input  soc_pkg::wb_req_t i_wb,
  output soc_pkg::wb_rsp_t o_wb,
  output logic             o_uart_tx
);

  soc_pkg::wb_req_t lmem_req;
  soc_pkg::wb_rsp_t lmem_rsp;
  soc_pkg::wb_req_t uart_req;
  soc_pkg::wb_rsp_t uart_rsp;

  soc_fabric fabric (
    .clk_i     (clk_i),
    .i_rst_n   (i_rst_n),
    .i_wb      (i_wb),
    .o_wb      (o_wb),
    .o_lmem_req(lmem_req),
    .i_lmem_rsp(lmem_rsp),
    .o_uart_req(uart_req),
    .i_uart_rsp(uart_rsp)
  );

  soc_lmem lmem (
    .clk_i  (clk_i),
    .i_rst_n(i_rst_n),
    .i_req  (lmem_req),
    .o_rsp  (lmem_rsp)
  );

  soc_uart uart_core (
    .clk_i    (clk_i),
    .i_rst_n  (i_rst_n),
    .i_req    (uart_req),
    .o_rsp    (uart_rsp),
    .o_uart_tx(o_uart_tx)  // Idles high
  );

endmodule

//--- tb/soc_properties.sv
// Concurrent assertions on the bus fabric and their bind into soc_fabric
module soc_properties (
  input logic             clk_i,
  input logic             i_rst_n,
  input soc_pkg::wb_req_t i_wb,
  input soc_pkg::wb_rsp_t o_wb,
  input soc_pkg::wb_req_t o_lmem_req,
  input soc_pkg::wb_req_t o_uart_req
);

  a_ack_err_excl: assert property (@(posedge clk_i) disable iff (!i_rst_n)
    !(o_wb.ack && o_wb.err))
    else $error("ack and err are high together on the manager reply");

  // Replies only inside an active request
  a_reply_in_req: assert property (@(posedge clk_i) disable iff (!i_rst_n)
    (o_wb.ack || o_wb.err) |-> (i_wb.cyc && i_wb.stb))
    else $error("reply seen without cyc and stb");

  a_one_stb: assert property (@(posedge clk_i) disable iff (!i_rst_n)
    !(o_lmem_req.stb && o_uart_req.stb))
    else $error("subordinate strobes overlap");

endmodule

bind soc_fabric soc_properties props (
  .clk_i     (clk_i),
  .i_rst_n   (i_rst_n),
  .i_wb      (i_wb),
  .o_wb      (o_wb),
  .o_lmem_req(o_lmem_req),
  .o_uart_req(o_uart_req)
);

//--- tb/soc_tb.sv
// Testbench for soc_top with a trace reader, bus manager, serial line monitor,
// check task, watchdog and summary
module soc_tb;

  localparam int FRAME_CLKS = soc_pkg::UART_FRAME_BITS * soc_pkg::UART_CLKS_PER_BIT;

  logic             clk_i = 1'b0;
  logic             i_rst_n;
  soc_pkg::wb_req_t i_wb;
  soc_pkg::wb_rsp_t o_wb;
  logic             o_uart_tx;

  // One entry per trace operation
  byte                        op_q [$];
  logic [soc_pkg::ADDR_W-1:0] adr_q [$];
  logic [soc_pkg::DATA_W-1:0] dat_q [$];
  logic [soc_pkg::DATA_W-1:0] exp_q [$];
  int                         line_q [$];
  bit                         trace_loaded = 1'b0;

  logic [7:0] tx_exp_q [$];  // Bytes written to the UART
  logic [7:0] rx_q [$];      // Bytes seen on the serial line
  int         n_checks = 0;
  int         n_errors = 0;

  soc_top uut (
    .clk_i    (clk_i),
    .i_rst_n  (i_rst_n),
    .i_wb     (i_wb),
    .o_wb     (o_wb),
    .o_uart_tx(o_uart_tx)
  );

  always #4 clk_i = ~clk_i;

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    n_checks++;
    if (act !== exp) begin
      n_errors++;
      $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic load_trace();
    int          fd;
    int          line_no;
    string       text;
    byte         op;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [31:0] exp;
    line_no = 0;
    fd = $fopen("tb/soc_trace.txt", "r");
    if (fd == 0) begin
      $display("Could not open the trace file tb/soc_trace.txt");
    end else begin
      while ($fgets(text, fd) != 0) begin
        line_no++;
        if (text.len() < 2 || text[0] == "#") continue;  // Blank or comment
        if ($sscanf(text, "%c %h %h %h", op, adr, dat, exp) != 4) begin
          n_errors++;
          $display("Malformed trace line %0d", line_no);
        end else begin
          op_q.push_back(op);
          adr_q.push_back(adr[soc_pkg::ADDR_W-1:0]);
          dat_q.push_back(dat);
          exp_q.push_back(exp);
          line_q.push_back(line_no);
        end
      end
      $fclose(fd);
    end
  endtask

  // Single Wishbone classic transfer, also notes any low level on the serial line
  task automatic bus_access(input logic we, input logic [soc_pkg::ADDR_W-1:0] adr,
                            input logic [soc_pkg::DATA_W-1:0] dat,
                            input logic [soc_pkg::SEL_W-1:0] sel,
                            output soc_pkg::wb_rsp_t rsp, output logic tx_low);
    soc_pkg::wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = dat;
    req.sel = sel;
    tx_low  = 1'b0;
    @(posedge clk_i);
    i_wb <= req;
    do begin
      @(negedge clk_i);
      tx_low = tx_low | (o_uart_tx !== 1'b1);
    end while (o_wb.ack !== 1'b1 && o_wb.err !== 1'b1);
    rsp = o_wb;
    @(posedge clk_i);
    i_wb <= '0;  // Drop cyc and stb for at least one cycle
  endtask

  // Wait until every written byte has left the line and the stop bit is over
  task automatic wait_line_idle();
    while (rx_q.size() < tx_exp_q.size()) @(posedge clk_i);
    repeat (soc_pkg::UART_CLKS_PER_BIT) @(posedge clk_i);
  endtask

  task automatic run_op(input int i);
    soc_pkg::wb_rsp_t rsp;
    logic             tx_low;
    string            name;
    int               sent;
    name = $sformatf("line %0d %c %h", line_q[i], op_q[i], adr_q[i]);
    sent = tx_exp_q.size();
    case (op_q[i])
      "W": begin
        bus_access(1'b1, adr_q[i], dat_q[i], '1, rsp, tx_low);
        check({name, " ack"}, 32'd1, 32'(rsp.ack));
      end
      "B": begin
        bus_access(1'b1, adr_q[i], dat_q[i], exp_q[i][soc_pkg::SEL_W-1:0], rsp, tx_low);
        check({name, " ack"}, 32'd1, 32'(rsp.ack));
      end
      "R": begin
        if (adr_q[i][soc_pkg::ADDR_W-1 -: soc_pkg::DECODE_W] ==
            soc_pkg::UART_BASE[soc_pkg::ADDR_W-1 -: soc_pkg::DECODE_W]) begin
          wait_line_idle();
        end
        bus_access(1'b0, adr_q[i], '0, '1, rsp, tx_low);
        check({name, " ack"}, 32'd1, 32'(rsp.ack));
        check({name, " data"}, exp_q[i], rsp.dat);
      end
      "E": begin
        wait_line_idle();
        bus_access(1'b1, adr_q[i], dat_q[i], '1, rsp, tx_low);
        check({name, " err"}, 32'd1, 32'(rsp.err));
        check({name, " ack"}, 32'd0, 32'(rsp.ack));
        check({name, " tx went low"}, 32'd0, 32'(tx_low));
      end
      "T": begin
        tx_exp_q.push_back(exp_q[i][7:0]);
        bus_access(1'b1, adr_q[i], dat_q[i], '1, rsp, tx_low);
        check({name, " ack"}, 32'd1, 32'(rsp.ack));
        // A write to a busy UART is acked only after the earlier frame ends
        check({name, " frames done at ack"}, sent, rx_q.size());
      end
      default: begin
        n_errors++;
        $display("Unknown operation %c on trace line %0d", op_q[i], line_q[i]);
      end
    endcase
  endtask

  initial begin : serial_monitor
    logic [7:0] rx_byte;
    wait (i_rst_n === 1'b1);
    forever begin
      @(negedge o_uart_tx);
      repeat (soc_pkg::UART_CLKS_PER_BIT / 2) @(negedge clk_i);  // Middle of start bit
      if (o_uart_tx !== 1'b0) begin
        n_errors++;
        $display("Serial line went low but the start bit did not hold");
      end else begin
        for (int b = 0; b < 8; b++) begin
          repeat (soc_pkg::UART_CLKS_PER_BIT) @(negedge clk_i);
          rx_byte[b] = o_uart_tx;  // LSB first
        end
        repeat (soc_pkg::UART_CLKS_PER_BIT) @(negedge clk_i);
        if (o_uart_tx !== 1'b1) begin
          n_errors++;
          $display("Serial frame ended without a stop bit");
        end
        rx_q.push_back(rx_byte);
      end
    end
  end

  initial begin : watchdog
    wait (trace_loaded);
    #(op_q.size() * (FRAME_CLKS + 20) * 8);
    $display("Timeout, the bus or the serial line stopped making progress");
    $display("TEST RESULT: FAIL");
    $finish;
  end

  initial begin : main
    i_rst_n = 1'b0;
    i_wb    = '0;
    load_trace();
    if (op_q.size() == 0) begin
      $display("No operations were read from the trace file");
      $display("TEST RESULT: FAIL");
      $finish;
    end else begin
      trace_loaded = 1'b1;
      repeat (3) @(posedge clk_i);
      i_rst_n <= 1'b1;
      @(negedge clk_i);
      check("tx idle after reset", 32'd1, 32'(o_uart_tx));
      for (int i = 0; i < op_q.size(); i++) begin
        run_op(i);
      end
      wait_line_idle();
      check("serial byte count", tx_exp_q.size(), rx_q.size());
      foreach (tx_exp_q[k]) begin
        check($sformatf("serial byte %0d", k), tx_exp_q[k], rx_q[k]);
      end
      $display("Checks: %0d, errors: %0d", n_checks, n_errors);
      if (n_errors == 0) begin
        $display("TEST RESULT: PASS");
      end else begin
        $display("TEST RESULT: FAIL");
      end
      $finish;
    end
  end

endmodule

//--- tb/soc_trace.txt
# op addr data expected, all hex. W B T write, R reads and compares, E expects err
# B takes its byte selects from the expected column, T sends the low data byte
W 0000 01234567 0
W 0004 89abcdef 0
W 03fc deadbeef 0
R 0000 0 01234567
R 0004 0 89abcdef
R 03fc 0 deadbeef
W 0010 11223344 0
B 0010 aabbccdd 5
R 0010 0 11bb33dd
W 0014 cafef00d 0
B 0014 12345678 c
R 0014 0 1234f00d
B 0014 000000aa 1
R 0014 0 1234f0aa
E 4000 0 0
E 0400 0 0
R 8004 0 0
T 8000 55 55
T 8000 000001a3 a3
R 0000 0 01234567
T 8000 0f 0f
T 8000 f0 f0
R 8004 0 0
R 8000 0 0
E 8004 1 0
E 8010 0 0

//--- tb.f
source/soc_pkg.sv
source/soc_fabric.sv
source/soc_lmem.sv
source/soc_uart.sv
source/soc_top.sv
tb/soc_properties.sv
tb/soc_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module soc_tb \
  -f tb.f -Mdir obj_dir -o soc_sim > build.log 2>&1 &&
  ./obj_dir/soc_sim > sim.log 2>&1 ||
  { echo "Build or simulation failed, see build.log and sim.log"; exit 1; }

grep -qx "TEST RESULT: PASS" sim.log && echo "Simulation passed" ||
  { echo "Simulation failed, see sim.log"; exit 1; }
